// ==== design/nn_ctrl_pkg.sv ====
// forward-pass sequencer definitions
// layer size tables, memory address widths and the packed structs that
// travel between the sequencer blocks and out of the top level

package nn_ctrl_pkg;

  // ------------------------------------------------------------
  // datapath and memory sizing
  // ------------------------------------------------------------

  localparam int data_w      = 16;
  localparam int lanes       = 4;
  localparam int num_layers  = 4;

  localparam int wt_addr_w   = 9;
  localparam int bias_addr_w = 2;
  localparam int int_addr_w  = 2;

  // ------------------------------------------------------------
  // basic types
  // ------------------------------------------------------------

  typedef logic [data_w*lanes-1:0] lane_vec_t;
  typedef logic [1:0]              layer_idx_t;
  typedef logic [2:0]              neuron_idx_t;

  typedef enum logic [2:0] {
    idle,
    load_inp,
    load_mem,
    acc,
    done
  } phase_t;

  // ------------------------------------------------------------
  // per-layer tables, indexed by layer number
  // ------------------------------------------------------------

  localparam neuron_idx_t layer_neurons [num_layers] = '{3'd4, 3'd6, 3'd3, 3'd5};

  // each weight base is the running sum of the earlier layers' neuron counts
  localparam logic [wt_addr_w-1:0] weight_base [num_layers] =
    '{9'd0, 9'd4, 9'd10, 9'd13};

  // one bias word per layer
  localparam logic [bias_addr_w-1:0] bias_base [num_layers] =
    '{2'd0, 2'd1, 2'd2, 2'd3};

  // ------------------------------------------------------------
  // handshake payloads and control bundles
  // ------------------------------------------------------------

  typedef struct packed {
    logic use_target;
  } cmd_t;

  typedef struct packed {
    logic      use_target;
    lane_vec_t result;
  } resp_t;

  // accm_clr is active low, so a zero word keeps the accumulator cleared
  typedef struct packed {
    logic piso_load;
    logic piso_shift;
    logic accm_en;
    logic accm_clr;
    logic accm_init;
  } dp_ctrl_t;

  typedef struct packed {
    logic                 en;
    logic                 target;
    logic [wt_addr_w-1:0] addr;
  } wt_req_t;

  typedef struct packed {
    logic                   en;
    logic                   target;
    logic [bias_addr_w-1:0] addr;
  } bias_req_t;

  typedef struct packed {
    logic                  en;
    logic [int_addr_w-1:0] addr;
    lane_vec_t             data;
  } int_wr_t;

endpackage

// ==== design/fwd_layer_fsm.sv ====
// forward-pass sequencing FSM
// accepts a command, walks every layer through load_inp, load_mem and
// one acc cycle per neuron, then holds the response until it is taken

module fwd_layer_fsm (
  input  logic                    clk,
  input  logic                    rst_b,
  input  nn_ctrl_pkg::cmd_t       cmd,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  nn_ctrl_pkg::lane_vec_t  int_out_q,
  output nn_ctrl_pkg::resp_t      resp,
  output logic                    resp_valid,
  input  logic                    resp_ready,
  output nn_ctrl_pkg::phase_t     phase,
  output nn_ctrl_pkg::layer_idx_t layer_idx,
  output nn_ctrl_pkg::neuron_idx_t neuron_idx,
  output logic                    net_target,
  output nn_ctrl_pkg::dp_ctrl_t   dp_ctrl
);

  nn_ctrl_pkg::phase_t      phase_nxt;
  nn_ctrl_pkg::neuron_idx_t last_neuron;
  nn_ctrl_pkg::lane_vec_t   result_q;
  logic                     last_layer;
  logic                     layer_end;
  logic                     cmd_fire;

  assign cmd_fire    = cmd_valid && cmd_ready;
  assign last_neuron = nn_ctrl_pkg::layer_neurons[layer_idx] - 3'd1;
  assign last_layer  = (layer_idx == nn_ctrl_pkg::layer_idx_t'(nn_ctrl_pkg::num_layers - 1));
  assign layer_end   = (phase == nn_ctrl_pkg::acc) && (neuron_idx == last_neuron);

  // ------------------------------------------------------------
  // phase sequencing
  // ------------------------------------------------------------

  always_comb begin
    phase_nxt = phase;
    case (phase)
      nn_ctrl_pkg::idle: begin
        if (cmd_fire) begin
          phase_nxt = nn_ctrl_pkg::load_inp;
        end
      end
      nn_ctrl_pkg::load_inp: phase_nxt = nn_ctrl_pkg::load_mem;
      nn_ctrl_pkg::load_mem: phase_nxt = nn_ctrl_pkg::acc;
      nn_ctrl_pkg::acc: begin
        if (layer_end) begin
          phase_nxt = last_layer ? nn_ctrl_pkg::done : nn_ctrl_pkg::load_inp;
        end
      end
      nn_ctrl_pkg::done: begin
        if (resp_ready) begin
          phase_nxt = nn_ctrl_pkg::idle;
        end
      end
      default: phase_nxt = nn_ctrl_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      phase      <= nn_ctrl_pkg::idle;
      layer_idx  <= '0;
      neuron_idx <= '0;
      net_target <= 1'b0;
    end else begin
      phase <= phase_nxt;
      if (cmd_fire) begin
        net_target <= cmd.use_target;
        layer_idx  <= '0;
      end
      // neuron count restarts for every layer, layer count steps at its last neuron
      if (phase == nn_ctrl_pkg::load_inp) begin
        neuron_idx <= '0;
      end else if (phase == nn_ctrl_pkg::acc) begin
        neuron_idx <= neuron_idx + 3'd1;
      end
      if (layer_end && !last_layer) begin
        layer_idx <= layer_idx + 2'd1;
      end
    end
  end

  // the final layer output is valid on the edge that enters done
  always_ff @(posedge clk) begin
    if (layer_end && last_layer) begin
      result_q <= int_out_q;
    end
  end

  // ------------------------------------------------------------
  // handshake and datapath control decode
  // ------------------------------------------------------------

  assign cmd_ready       = (phase == nn_ctrl_pkg::idle);
  assign resp_valid      = (phase == nn_ctrl_pkg::done);
  assign resp.use_target = net_target;
  assign resp.result     = result_q;

  always_comb begin
    dp_ctrl            = '0;
    dp_ctrl.piso_load  = (phase == nn_ctrl_pkg::load_inp);
    dp_ctrl.piso_shift = (phase == nn_ctrl_pkg::acc);
    dp_ctrl.accm_en    = (phase == nn_ctrl_pkg::acc);
    // accumulator leaves clear only while a layer streams its weights
    dp_ctrl.accm_clr   = (phase == nn_ctrl_pkg::acc);
    // first neuron of a layer starts the sum from the bias
    dp_ctrl.accm_init  = (phase == nn_ctrl_pkg::acc) && (neuron_idx == '0);
  end

endmodule

// ==== design/param_addr_gen.sv ====
// weight and bias read-address generator
// issues one bias read per layer and one weight read per neuron, tagged
// with the target or model network selection

module param_addr_gen (
  input  logic                    clk,
  input  logic                    rst_b,
  input  nn_ctrl_pkg::phase_t     phase,
  input  nn_ctrl_pkg::layer_idx_t layer_idx,
  input  logic                    net_target,
  output nn_ctrl_pkg::wt_req_t    wt_req,
  output nn_ctrl_pkg::bias_req_t  bias_req
);

  logic [nn_ctrl_pkg::wt_addr_w-1:0] wt_addr_q;

  // ------------------------------------------------------------
  // weight address register
  // ------------------------------------------------------------

  // loaded with the layer base ahead of the first acc cycle, then it
  // steps once per neuron so every acc cycle sees its own weight row
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wt_addr_q <= '0;
    end else begin
      case (phase)
        nn_ctrl_pkg::load_mem: wt_addr_q <= nn_ctrl_pkg::weight_base[layer_idx];
        nn_ctrl_pkg::acc:      wt_addr_q <= wt_addr_q + 9'd1;
        default:               wt_addr_q <= wt_addr_q;
      endcase
    end
  end

  // ------------------------------------------------------------
  // read requests
  // ------------------------------------------------------------

  always_comb begin
    wt_req.en     = (phase == nn_ctrl_pkg::acc);
    wt_req.target = net_target;
    wt_req.addr   = wt_addr_q;
  end

  // bias word is fetched while the input register settles
  always_comb begin
    bias_req.en     = (phase == nn_ctrl_pkg::load_mem);
    bias_req.target = net_target;
    bias_req.addr   = nn_ctrl_pkg::bias_base[layer_idx];
  end

endmodule

// ==== design/int_op_writer.sv ====
// intermediate-output write-back unit
// captures the datapath output when the next layer loads its inputs and
// writes it to the intermediate-output memory one cycle later

module int_op_writer (
  input  logic                    clk,
  input  logic                    rst_b,
  input  nn_ctrl_pkg::phase_t     phase,
  input  nn_ctrl_pkg::layer_idx_t layer_idx,
  input  nn_ctrl_pkg::lane_vec_t  int_out_q,
  output nn_ctrl_pkg::int_wr_t    int_wr
);

  nn_ctrl_pkg::lane_vec_t             cap_q;
  logic [nn_ctrl_pkg::int_addr_w-1:0] wr_addr_q;
  logic                               wr_en;

  // layer 0 starts from the network input, so nothing to store yet
  assign wr_en = (phase == nn_ctrl_pkg::load_mem) && (layer_idx != '0);

  always_ff @(posedge clk) begin
    if (phase == nn_ctrl_pkg::load_inp) begin
      cap_q <= int_out_q;
    end
  end

  // write address restarts while idle and advances after every write
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_addr_q <= '0;
    end else if (phase == nn_ctrl_pkg::idle) begin
      wr_addr_q <= '0;
    end else if (wr_en) begin
      wr_addr_q <= wr_addr_q + 2'd1;
    end
  end

  always_comb begin
    int_wr.en   = wr_en;
    int_wr.addr = wr_addr_q;
    int_wr.data = cap_q;
  end

endmodule

// ==== design/fwd_pass_ctrl.sv ====
// forward-pass controller top level
// ties the sequencing FSM to the parameter address generator and the
// intermediate-output write-back unit

module fwd_pass_ctrl (
  input  logic                   clk,
  input  logic                   rst_b,
  input  nn_ctrl_pkg::cmd_t      cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  output nn_ctrl_pkg::resp_t     resp,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  input  nn_ctrl_pkg::lane_vec_t int_out_q,
  output nn_ctrl_pkg::dp_ctrl_t  dp_ctrl,
  output nn_ctrl_pkg::wt_req_t   wt_req,
  output nn_ctrl_pkg::bias_req_t bias_req,
  output nn_ctrl_pkg::int_wr_t   int_wr
);

  // ------------------------------------------------------------
  // sequencer state shared by the three blocks
  // ------------------------------------------------------------

  nn_ctrl_pkg::phase_t      phase;
  nn_ctrl_pkg::layer_idx_t  layer_idx;
  logic                     net_target;

  fwd_layer_fsm u_fsm (
    .clk        (clk),
    .rst_b      (rst_b),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .int_out_q  (int_out_q),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .phase      (phase),
    .layer_idx  (layer_idx),
    .neuron_idx (),
    .net_target (net_target),
    .dp_ctrl    (dp_ctrl)
  );

  param_addr_gen u_addr_gen (
    .clk        (clk),
    .rst_b      (rst_b),
    .phase      (phase),
    .layer_idx  (layer_idx),
    .net_target (net_target),
    .wt_req     (wt_req),
    .bias_req   (bias_req)
  );

  int_op_writer u_int_wr (
    .clk        (clk),
    .rst_b      (rst_b),
    .phase      (phase),
    .layer_idx  (layer_idx),
    .int_out_q  (int_out_q),
    .int_wr     (int_wr)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// clock and reset source for the forward-pass controller testbench
// free-running clock, reset held low for the first eight rising edges

module tb_clk_gen (
  output logic clk,
  output logic rst_b
);

  localparam int half_period  = 5;
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst_b = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_b <= 1'b1;
  end

endmodule

// ==== verif/fwd_pass_ctrl_chk.sv ====
// protocol checker for the forward-pass controller
// command and response handshake rules and the memory read windows

module fwd_pass_ctrl_chk (
  input logic                   clk,
  input logic                   rst_b,
  input logic                   cmd_valid,
  input logic                   cmd_ready,
  input nn_ctrl_pkg::resp_t     resp,
  input logic                   resp_valid,
  input logic                   resp_ready,
  input nn_ctrl_pkg::wt_req_t   wt_req,
  input nn_ctrl_pkg::bias_req_t bias_req
);

  // failure tallies that the testbench reads at the end of the run
  int ready_fails = 0;
  int hold_fails  = 0;
  int read_fails  = 0;
  int fail_count;
  logic busy;

  assign fail_count = ready_fails + hold_fails + read_fails;

  // a pass is in flight from command acceptance until its response is taken
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      busy <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      busy <= 1'b1;
    end else if (resp_valid && resp_ready) begin
      busy <= 1'b0;
    end
  end

  // a new command is only taken while the sequencer is idle
  ready_only_idle: assert property (
    @(posedge clk) disable iff (!rst_b)
    busy |-> !cmd_ready
  ) else begin
    $error("cmd_ready high while the sequencer is busy");
    ready_fails = ready_fails + 1;
  end

  resp_held: assert property (
    @(posedge clk) disable iff (!rst_b)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
  ) else begin
    $error("response changed or dropped before it was accepted");
    hold_fails = hold_fails + 1;
  end

  no_read_when_quiet: assert property (
    @(posedge clk) disable iff (!rst_b)
    (!busy || resp_valid) |-> !(wt_req.en || bias_req.en)
  ) else begin
    $error("memory read issued in idle or done");
    read_fails = read_fails + 1;
  end

endmodule

bind fwd_pass_ctrl fwd_pass_ctrl_chk u_chk (
  .clk        (clk),
  .rst_b      (rst_b),
  .cmd_valid  (cmd_valid),
  .cmd_ready  (cmd_ready),
  .resp       (resp),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .wt_req     (wt_req),
  .bias_req   (bias_req)
);

// ==== verif/fwd_pass_ctrl_tb.sv ====
// testbench for the forward-pass controller
// applies a table of commands, collects every read, write-back and the
// response of a pass and compares them with a schedule built from layer sizes

module fwd_pass_ctrl_tb;

  localparam int num_rows   = 6;
  localparam int num_layers = 4;
  localparam int max_stall  = 7;
  localparam int done_cycle = 27;
  localparam int margin     = 20;
  localparam int wd_limit   =
    10 * (8 + margin + num_rows * (done_cycle + max_stall + margin));
  localparam int layer_sizes [num_layers] = '{4, 6, 3, 5};

  typedef struct packed {
    logic                   use_target;
    nn_ctrl_pkg::lane_vec_t base;
    logic [3:0]             stall;
  } row_t;

  logic                   clk;
  logic                   rst_b;
  nn_ctrl_pkg::cmd_t      cmd;
  logic                   cmd_valid;
  logic                   cmd_ready;
  nn_ctrl_pkg::resp_t     resp;
  logic                   resp_valid;
  logic                   resp_ready;
  nn_ctrl_pkg::lane_vec_t int_out_q;
  nn_ctrl_pkg::dp_ctrl_t  dp_ctrl;
  nn_ctrl_pkg::wt_req_t   wt_req;
  nn_ctrl_pkg::bias_req_t bias_req;
  nn_ctrl_pkg::int_wr_t   int_wr;

  row_t                   rows [num_rows];
  int                     errors;
  int                     rows_failed;
  int                     edge_cnt;
  int                     take_edge;
  int                     init_cnt;
  int                     first_valid;
  int                     wt_seen [$];
  int                     bias_seen [$];
  int                     wr_addr_seen [$];
  nn_ctrl_pkg::lane_vec_t wr_data_seen [$];

  tb_clk_gen u_clk_gen (.clk (clk), .rst_b (rst_b));

  fwd_pass_ctrl uut (
    .clk        (clk),
    .rst_b      (rst_b),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .int_out_q  (int_out_q),
    .dp_ctrl    (dp_ctrl),
    .wt_req     (wt_req),
    .bias_req   (bias_req),
    .int_wr     (int_wr)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  task automatic wait_edge();
    @(posedge clk);
    edge_cnt = edge_cnt + 1;
  endtask

  task automatic report_mismatch(string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors = errors + 1;
  endtask

  // layer whose load_inp falls in the given cycle after acceptance, or -1
  function automatic int load_inp_layer(int cyc);
    int start;
    int l;
    start = 1;
    for (l = 0; l < num_layers; l++) begin
      if (cyc == start) begin
        return l;
      end
      start = start + 2 + layer_sizes[l];
    end
    return -1;
  endfunction

  // datapath controls for the given cycle after acceptance, zero outside acc
  // and load_inp so the accumulator stays cleared
  function automatic nn_ctrl_pkg::dp_ctrl_t expected_ctrl(int cyc);
    nn_ctrl_pkg::dp_ctrl_t c;
    int start;
    int l;
    c = '0;
    start = 1;
    for (l = 0; l < num_layers; l++) begin
      if (cyc == start) begin
        c.piso_load = 1'b1;
      end else if (cyc >= start + 2 && cyc < start + 2 + layer_sizes[l]) begin
        c.piso_shift = 1'b1;
        c.accm_en    = 1'b1;
        c.accm_clr   = 1'b1;
        c.accm_init  = (cyc == start + 2);
      end
      start = start + 2 + layer_sizes[l];
    end
    return c;
  endfunction

  task automatic fill_table();
    rows[0] = '{use_target: 1'b0, base: 64'h1000_2000_3000_4000, stall: 4'd0};
    rows[1] = '{use_target: 1'b1, base: 64'h0123_4567_89ab_cdef, stall: 4'd3};
    rows[2] = '{use_target: 1'b1, base: 64'hffff_0000_ffff_0000, stall: 4'd0};
    rows[3] = '{use_target: 1'b0, base: 64'h5a5a_a5a5_5a5a_a5a0, stall: 4'd1};
    rows[4] = '{use_target: 1'b1, base: 64'h0f0f_f0f0_0f0f_f0f0, stall: 4'd0};
    rows[5] = '{use_target: 1'b1, base: 64'h7fff_8000_0001_fffe, stall: 4'd0};
    // rows 2, 4 and 5 draw their back-pressure length at random
    rows[2].stall = 4'($urandom % (max_stall + 1));
    rows[4].stall = 4'($urandom % (max_stall + 1));
    rows[5].stall = 4'($urandom % (max_stall + 1));
  endtask

  // ------------------------------------------------------------
  // per-cycle drive and sampling
  // ------------------------------------------------------------

  task automatic drive_next(int idx, int cyc);
    int lay;
    lay = load_inp_layer(cyc + 1);
    if (lay >= 0) begin
      int_out_q <= rows[idx].base + 64'(lay);
    end
    // the datapath output moves on once done starts and the response must ignore it
    if (cyc + 1 == done_cycle) begin
      int_out_q <= ~rows[idx].base;
      if (rows[idx].stall != 0 && idx + 1 < num_rows) begin
        cmd.use_target <= rows[idx + 1].use_target;
        cmd_valid      <= 1'b1;
      end
    end
    resp_ready <= (cyc + 1 >= done_cycle + int'(rows[idx].stall));
  endtask

  task automatic sample_cycle(int idx, int cyc);
    row_t                  r;
    nn_ctrl_pkg::dp_ctrl_t exp_ctrl;
    r = rows[idx];
    exp_ctrl = expected_ctrl(cyc);
    if (dp_ctrl !== exp_ctrl) begin
      report_mismatch($sformatf("dp_ctrl %b in cycle %0d, expected %b", dp_ctrl, cyc,
                                exp_ctrl));
    end
    if (wt_req.en) begin
      wt_seen.push_back(int'(wt_req.addr));
      if (wt_req.target !== r.use_target) begin
        report_mismatch($sformatf("weight read in cycle %0d has wrong network tag", cyc));
      end
    end
    if (bias_req.en) begin
      bias_seen.push_back(int'(bias_req.addr));
      if (bias_req.target !== r.use_target) begin
        report_mismatch($sformatf("bias read in cycle %0d has wrong network tag", cyc));
      end
    end
    if (int_wr.en) begin
      wr_addr_seen.push_back(int'(int_wr.addr));
      wr_data_seen.push_back(int_wr.data);
    end
    if (dp_ctrl.accm_init) begin
      init_cnt = init_cnt + 1;
    end
    if (resp_valid && first_valid < 0) begin
      first_valid = cyc;
    end
    // back-pressure cycles hold the response and refuse new commands
    if (first_valid >= 0 && !resp_ready) begin
      if (!resp_valid) begin
        report_mismatch($sformatf("resp_valid dropped in stall cycle %0d", cyc));
      end
      if (cmd_ready) begin
        report_mismatch($sformatf("cmd_ready high in stall cycle %0d", cyc));
      end
      if (resp.result !== r.base + 64'd3) begin
        report_mismatch($sformatf("resp.result %h in stall cycle %0d", resp.result, cyc));
      end
    end
  endtask

  task automatic check_pass(int idx);
    int n;
    int base_acc;
    int l;
    int k;
    if (first_valid != done_cycle) begin
      report_mismatch($sformatf("resp_valid rose in cycle %0d, expected %0d",
                                first_valid, done_cycle));
    end
    n = 0;
    base_acc = 0;
    for (l = 0; l < num_layers; l++) begin
      for (k = 0; k < layer_sizes[l]; k++) begin
        if (n < wt_seen.size() && wt_seen[n] != base_acc + k) begin
          report_mismatch($sformatf("weight read %0d at %0d, expected %0d",
                                    n, wt_seen[n], base_acc + k));
        end
        n = n + 1;
      end
      base_acc = base_acc + layer_sizes[l];
    end
    if (wt_seen.size() != n) begin
      report_mismatch($sformatf("%0d weight reads, expected %0d", wt_seen.size(), n));
    end
    if (bias_seen.size() != num_layers) begin
      report_mismatch($sformatf("%0d bias reads, expected %0d", bias_seen.size(), num_layers));
    end
    for (l = 0; l < bias_seen.size(); l++) begin
      if (bias_seen[l] != l) begin
        report_mismatch($sformatf("bias read %0d at %0d, expected %0d", l, bias_seen[l], l));
      end
    end
    if (wr_addr_seen.size() != num_layers - 1) begin
      report_mismatch($sformatf("%0d intermediate writes, expected %0d",
                                wr_addr_seen.size(), num_layers - 1));
    end
    for (l = 0; l < wr_addr_seen.size(); l++) begin
      if (wr_addr_seen[l] != l || wr_data_seen[l] !== rows[idx].base + 64'(l + 1)) begin
        report_mismatch($sformatf("write %0d to %0d data %h, expected %0d data %h", l,
                                  wr_addr_seen[l], wr_data_seen[l], l,
                                  rows[idx].base + 64'(l + 1)));
      end
    end
    if (init_cnt != num_layers) begin
      report_mismatch($sformatf("%0d accm_init cycles, expected %0d", init_cnt, num_layers));
    end
  endtask

  // ------------------------------------------------------------
  // one table row, command to accepted response
  // ------------------------------------------------------------

  task automatic run_row(int idx);
    int cyc;
    int err_start;
    bit preoffered;
    bit taken;
    err_start = errors;
    wt_seen.delete();
    bias_seen.delete();
    wr_addr_seen.delete();
    wr_data_seen.delete();
    init_cnt = 0;
    first_valid = -1;
    preoffered = cmd_valid;
    if (!preoffered) begin
      cmd.use_target <= rows[idx].use_target;
      cmd_valid      <= 1'b1;
    end
    wait_edge();
    while (!(cmd_valid && cmd_ready)) begin
      wait_edge();
    end
    if (preoffered && edge_cnt != take_edge + 1) begin
      report_mismatch($sformatf("waiting command taken %0d edges after the response",
                                edge_cnt - take_edge));
    end
    cmd_valid <= 1'b0;
    cyc = 0;
    drive_next(idx, cyc);
    taken = 1'b0;
    while (!taken) begin
      wait_edge();
      cyc = cyc + 1;
      sample_cycle(idx, cyc);
      if (resp_valid && resp_ready) begin
        taken = 1'b1;
        take_edge = edge_cnt;
        resp_ready <= 1'b0;
        if (resp.result !== rows[idx].base + 64'd3 ||
            resp.use_target !== rows[idx].use_target) begin
          report_mismatch($sformatf("response target %0b result %h", resp.use_target,
                                    resp.result));
        end
      end else begin
        drive_next(idx, cyc);
      end
    end
    check_pass(idx);
    if (errors != err_start) begin
      rows_failed = rows_failed + 1;
    end
    $display("row %0d target %0b stall %0d: %s", idx, rows[idx].use_target,
             rows[idx].stall, (errors == err_start) ? "ok" : "errors found");
  endtask

  // ------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------

  initial begin
    int idx;
    int asrt_fails;
    void'($urandom(32'hf1a011cf));
    cmd         = '0;
    cmd_valid   = 1'b0;
    resp_ready  = 1'b0;
    int_out_q   = '0;
    errors      = 0;
    rows_failed = 0;
    edge_cnt    = 0;
    take_edge   = -1;
    fill_table();
    while (rst_b !== 1'b1) begin
      wait_edge();
    end
    wait_edge();
    for (idx = 0; idx < num_rows; idx++) begin
      run_row(idx);
    end
    wait_edge();
    asrt_fails = uut.u_chk.fail_count;
    $display("rows %0d, passed %0d, failed %0d, mismatches %0d, assertion failures %0d",
             num_rows, num_rows - rows_failed, rows_failed, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(wd_limit);
    $display("watchdog expired at %0t, the DUT stopped making progress", $time);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/nn_ctrl_pkg.sv
design/fwd_layer_fsm.sv
design/param_addr_gen.sv
design/int_op_writer.sv
design/fwd_pass_ctrl.sv
verif/tb_clk_gen.sv
verif/fwd_pass_ctrl_chk.sv
verif/fwd_pass_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the forward-pass controller testbench with Verilator and run it;
# the run fails when the log holds the testbench fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="FAIL: see errors above"

verilator --binary --timing --assert -j 0 --top-module fwd_pass_ctrl_tb -f vlog.f \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vfwd_pass_ctrl_tb +verilator+error+limit+1000 2>&1 | tee "$log" \
  || { echo "simulation ended abnormally"; exit 1; }

grep -q "$fail_msg" "$log" && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
